/* files.f */
rtl/pcie_dl_pkg.sv
rtl/dl_stream_if.sv
rtl/dl_link_ctrl.sv
rtl/dl_fc_init.sv
rtl/dl_tx_seq.sv
rtl/dl_rx_parse.sv
rtl/dl_phy_arb.sv
rtl/pcie_dl_top.sv
bench/tb_pcie_dl.sv

/* Makefile */
SIM_BIN := obj_dir/Vtb_pcie_dl

.PHONY: all run lint clean

all: run

$(SIM_BIN): files.f $(wildcard rtl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_dl \
		-f files.f -o Vtb_pcie_dl

run: $(SIM_BIN)
	./$(SIM_BIN) | tee sim.log
	grep -qx "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module pcie_dl_top -f files.f

clean:
	rm -rf obj_dir sim.log

/* bench/tb_pcie_dl.sv */
`timescale 1ns/100ps

module tb_pcie_dl;
  import pcie_dl_pkg::*;

  localparam credit_t    DUT_CREDITS  = 8'd6;
  localparam int         FC_GAP       = 8;
  localparam credit_t    PEER_CREDITS = 8'd8;
  localparam int         TX_BURST     = 5;
  localparam int         HOLD_CYCLES  = 40;
  localparam int         WAIT_LIMIT   = 400;
  localparam logic [7:0] CODE_ACK     = 8'h00;
  localparam logic [7:0] CODE_NAK     = 8'h10;
  localparam logic [7:0] CODE_FC1     = 8'h40;
  localparam logic [7:0] CODE_UPD     = 8'h80;
  localparam logic [7:0] CODE_FC2     = 8'hC0;

  logic     clk_i;
  logic     rst_n_i;
  logic     phy_link_up_i;
  dl_word_t s_tlp_tdata_i;
  logic     s_tlp_tvalid_i;
  logic     s_tlp_tlast_i;
  logic     s_tlp_tready_o;
  dl_word_t m_tlp_tdata_o;
  logic     m_tlp_tvalid_o;
  logic     m_tlp_tlast_o;
  logic     m_tlp_tready_i;
  dl_word_t s_phy_tdata_i;
  logic     s_phy_tvalid_i;
  logic     s_phy_tlast_i;
  logic     s_phy_tuser_i;
  logic     s_phy_tready_o;
  dl_word_t m_phy_tdata_o;
  logic     m_phy_tvalid_o;
  logic     m_phy_tlast_o;
  logic     m_phy_tuser_o;
  logic     m_phy_tready_i;
  logic     fc_initialized_o;

  integer      seed;
  logic        phy_stall_en;
  logic        tlp_stall_en;
  logic        phy_rdy_next;
  logic        tlp_rdy_next;
  // Expected words carry tlast in bit 32
  logic [32:0] exp_tx_q[$];
  logic [32:0] exp_rx_q[$];
  dl_word_t    dllp_q[$];
  dl_word_t    tlp_buf[$];
  seq_num_t    tx_seq;
  seq_num_t    rx_seq;
  int          tx_pkts;
  int          checks;
  int          errors;
  int          tests;
  int          failed_tests;
  int          test_err_base;
  string       cur_test;
  int          base;
  int          i;

  pcie_dl_top #(
    .RX_HDR_CREDITS (DUT_CREDITS),
    .FC_REPEAT      (FC_GAP)
  ) DUT (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .phy_link_up_i    (phy_link_up_i),
    .s_tlp_tdata_i    (s_tlp_tdata_i),
    .s_tlp_tvalid_i   (s_tlp_tvalid_i),
    .s_tlp_tlast_i    (s_tlp_tlast_i),
    .s_tlp_tready_o   (s_tlp_tready_o),
    .m_tlp_tdata_o    (m_tlp_tdata_o),
    .m_tlp_tvalid_o   (m_tlp_tvalid_o),
    .m_tlp_tlast_o    (m_tlp_tlast_o),
    .m_tlp_tready_i   (m_tlp_tready_i),
    .s_phy_tdata_i    (s_phy_tdata_i),
    .s_phy_tvalid_i   (s_phy_tvalid_i),
    .s_phy_tlast_i    (s_phy_tlast_i),
    .s_phy_tuser_i    (s_phy_tuser_i),
    .s_phy_tready_o   (s_phy_tready_o),
    .m_phy_tdata_o    (m_phy_tdata_o),
    .m_phy_tvalid_o   (m_phy_tvalid_o),
    .m_phy_tlast_o    (m_phy_tlast_o),
    .m_phy_tuser_o    (m_phy_tuser_o),
    .m_phy_tready_i   (m_phy_tready_i),
    .fc_initialized_o (fc_initialized_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    #1000000;
    $display("Simulation time limit reached in test %s", cur_test);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic dl_word_t fc_dllp(logic [7:0] code, credit_t credits);
    return {code, 4'h0, credits, 12'h000};
  endfunction

  function automatic dl_word_t seq_dllp(logic [7:0] code, seq_num_t seq);
    return {code, 12'h000, seq};
  endfunction

  task automatic check_eq(input string what, input logic [32:0] expected,
                          input logic [32:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("CHECK FAILED %s (%s): expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("CHECK FAILED %s (%s): expected %0d, actual %0d", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string problem);
    checks++;
    assert (cond) else begin
      $display("Test %s: %s", cur_test, problem);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == test_err_base) begin
      $display("test %0d %s: passed", tests, cur_test);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, cur_test, errors - test_err_base);
      failed_tests++;
    end
  endtask

  // Random ready for both output streams
  initial begin
    m_phy_tready_i = 1'b1;
    m_tlp_tready_i = 1'b1;
    phy_rdy_next   = 1'b1;
    tlp_rdy_next   = 1'b1;
    forever begin
      @(posedge clk_i);
      phy_rdy_next = phy_stall_en ? (($random(seed) & 3) != 0) : 1'b1;
      tlp_rdy_next = tlp_stall_en ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk_i);
      m_phy_tready_i = phy_rdy_next;
      m_tlp_tready_i = tlp_rdy_next;
    end
  end

  // DLLPs from the PHY output are queued and TLP words go to the scoreboard
  always @(posedge clk_i) begin
    logic [32:0] exp_word;
    if (m_phy_tvalid_o && m_phy_tready_i) begin
      if (m_phy_tuser_o) begin
        check_true(m_phy_tlast_o, "DLLP word on the PHY output without tlast");
        dllp_q.push_back(m_phy_tdata_o);
      end else begin
        check_true(exp_tx_q.size() != 0, "TLP word on the PHY output with no TLP sent");
        if (exp_tx_q.size() != 0) begin
          exp_word = exp_tx_q.pop_front();
          check_eq("PHY TLP word", exp_word, {m_phy_tlast_o, m_phy_tdata_o});
        end
        if (m_phy_tlast_o) begin
          tx_pkts++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    logic [32:0] exp_word;
    if (m_tlp_tvalid_o && m_tlp_tready_i) begin
      check_true(exp_rx_q.size() != 0, "TLP output word with no received TLP expected");
      if (exp_rx_q.size() != 0) begin
        exp_word = exp_rx_q.pop_front();
        check_eq("received TLP word", exp_word, {m_tlp_tlast_o, m_tlp_tdata_o});
      end
    end
  end

  task automatic make_tlp();
    int len;
    int n;
    @(negedge clk_i);
    tlp_buf.delete();
    len = 1 + ($random(seed) & 3);
    for (n = 0; n < len; n++) begin
      tlp_buf.push_back($random(seed));
    end
  endtask

  task automatic expect_tx();
    int n;
    exp_tx_q.push_back({1'b0, 20'h0, tx_seq});
    for (n = 0; n < tlp_buf.size(); n++) begin
      exp_tx_q.push_back({n == tlp_buf.size() - 1, tlp_buf[n]});
    end
    tx_seq++;
  endtask

  task automatic tx_word(input dl_word_t w, input logic last);
    int t;
    @(negedge clk_i);
    s_tlp_tdata_i  = w;
    s_tlp_tvalid_i = 1'b1;
    s_tlp_tlast_i  = last;
    t = 0;
    @(posedge clk_i);
    while (!s_tlp_tready_o && t < WAIT_LIMIT) begin
      @(posedge clk_i);
      t++;
    end
    check_true(s_tlp_tready_o, "TLP input word was never accepted");
    if (last) begin
      @(negedge clk_i);
      s_tlp_tvalid_i = 1'b0;
      s_tlp_tlast_i  = 1'b0;
    end
  endtask

  task automatic drive_tx();
    int n;
    for (n = 0; n < tlp_buf.size(); n++) begin
      tx_word(tlp_buf[n], n == tlp_buf.size() - 1);
    end
  endtask

  task automatic wait_tx_drain();
    int t;
    t = 0;
    while (exp_tx_q.size() != 0 && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    check_true(exp_tx_q.size() == 0, "transmitted TLPs did not all reach the PHY output");
  endtask

  // Offer the first word and expect the credit gate to keep it out
  task automatic hold_tx();
    int  pkts;
    bit  blocked;
    @(negedge clk_i);
    s_tlp_tdata_i  = tlp_buf[0];
    s_tlp_tvalid_i = 1'b1;
    s_tlp_tlast_i  = (tlp_buf.size() == 1);
    pkts    = tx_pkts;
    blocked = 1'b1;
    repeat (HOLD_CYCLES) begin
      @(posedge clk_i);
      if (s_tlp_tready_o) begin
        blocked = 1'b0;
      end
    end
    check_true(blocked, "TLP input accepted with no header credit left");
    check_count("TLPs sent while out of credit", pkts, tx_pkts);
  endtask

  task automatic drop_tx();
    @(negedge clk_i);
    s_tlp_tvalid_i = 1'b0;
    s_tlp_tlast_i  = 1'b0;
  endtask

  task automatic phy_word(input dl_word_t w, input logic last, input logic user);
    int t;
    @(negedge clk_i);
    s_phy_tdata_i  = w;
    s_phy_tvalid_i = 1'b1;
    s_phy_tlast_i  = last;
    s_phy_tuser_i  = user;
    t = 0;
    @(posedge clk_i);
    while (!s_phy_tready_o && t < WAIT_LIMIT) begin
      @(posedge clk_i);
      t++;
    end
    check_true(s_phy_tready_o, "PHY input word was never accepted");
    if (last) begin
      @(negedge clk_i);
      s_phy_tvalid_i = 1'b0;
      s_phy_tlast_i  = 1'b0;
      s_phy_tuser_i  = 1'b0;
    end
  endtask

  task automatic wait_dllp(output dl_word_t w, output bit ok);
    int t;
    t = 0;
    while (dllp_q.size() == 0 && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    ok = (dllp_q.size() != 0);
    w  = '0;
    if (ok) begin
      w = dllp_q.pop_front();
    end else begin
      check_true(1'b0, "no DLLP arrived on the PHY output");
    end
  endtask

  task automatic bring_up(input credit_t peer_credits);
    dl_word_t w;
    bit       ok;
    int       n;
    dllp_q.delete();
    @(negedge clk_i);
    phy_link_up_i = 1'b1;
    // Partner silent, so InitFC1 keeps coming
    for (n = 0; n < 2; n++) begin
      wait_dllp(w, ok);
      if (ok) begin
        check_eq("repeated InitFC1", fc_dllp(CODE_FC1, DUT_CREDITS), w);
      end
    end
    phy_word(fc_dllp(CODE_FC1, peer_credits), 1'b1, 1'b1);
    // An InitFC1 offered before the partner's may still go out
    ok = 1'b1;
    n  = 0;
    w  = fc_dllp(CODE_FC1, DUT_CREDITS);
    while (ok && n < 3 && w == fc_dllp(CODE_FC1, DUT_CREDITS)) begin
      wait_dllp(w, ok);
      n++;
    end
    if (ok) begin
      check_eq("InitFC2 after partner InitFC1", fc_dllp(CODE_FC2, DUT_CREDITS), w);
    end
    phy_word(fc_dllp(CODE_FC2, peer_credits), 1'b1, 1'b1);
    n = 0;
    while (!fc_initialized_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    check_true(fc_initialized_o, "fc_initialized_o did not rise after the partner's InitFC2");
    repeat (2) @(negedge clk_i);
    dllp_q.delete();
  endtask

  task automatic recv_tlp(input bit good);
    dl_word_t w;
    bit       ok;
    int       n;
    seq_num_t hdr_seq;
    make_tlp();
    hdr_seq = good ? rx_seq : rx_seq + 12'd5;
    if (good) begin
      for (n = 0; n < tlp_buf.size(); n++) begin
        exp_rx_q.push_back({n == tlp_buf.size() - 1, tlp_buf[n]});
      end
    end
    phy_word({20'h0, hdr_seq}, 1'b0, 1'b0);
    for (n = 0; n < tlp_buf.size(); n++) begin
      phy_word(tlp_buf[n], n == tlp_buf.size() - 1, 1'b0);
    end
    wait_dllp(w, ok);
    if (ok && good) begin
      check_eq("Ack after good TLP", seq_dllp(CODE_ACK, rx_seq), w);
    end else if (ok) begin
      check_eq("Nak after bad TLP", seq_dllp(CODE_NAK, rx_seq - 12'd1), w);
    end
    check_count("TLP words still expected", 0, exp_rx_q.size());
    if (good) begin
      rx_seq++;
    end
  endtask

  initial begin
    seed           = 32'hc4748c7c;
    rst_n_i        = 1'b0;
    phy_link_up_i  = 1'b0;
    s_tlp_tdata_i  = '0;
    s_tlp_tvalid_i = 1'b0;
    s_tlp_tlast_i  = 1'b0;
    s_phy_tdata_i  = '0;
    s_phy_tvalid_i = 1'b0;
    s_phy_tlast_i  = 1'b0;
    s_phy_tuser_i  = 1'b0;
    phy_stall_en   = 1'b0;
    tlp_stall_en   = 1'b0;
    tx_seq         = '0;
    rx_seq         = '0;
    tx_pkts        = 0;
    checks         = 0;
    errors         = 0;
    tests          = 0;
    failed_tests   = 0;
    cur_test       = "reset";
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    start_test("link bring-up");
    check_count("m_phy_tvalid_o after reset", 0, m_phy_tvalid_o);
    check_count("m_tlp_tvalid_o after reset", 0, m_tlp_tvalid_o);
    check_count("fc_initialized_o after reset", 0, fc_initialized_o);
    bring_up(PEER_CREDITS);
    end_test();

    start_test("TLP transmit");
    phy_stall_en = 1'b1;
    base = tx_pkts;
    for (i = 0; i < TX_BURST; i++) begin
      make_tlp();
      expect_tx();
      drive_tx();
    end
    wait_tx_drain();
    check_count("TLPs on the PHY output", base + TX_BURST, tx_pkts);
    check_count("DLLPs during transmit", 0, dllp_q.size());
    end_test();

    start_test("credit gating");
    base = tx_pkts;
    for (i = 0; i < PEER_CREDITS - TX_BURST; i++) begin
      make_tlp();
      expect_tx();
      drive_tx();
    end
    wait_tx_drain();
    check_count("TLPs within the credit limit", base + PEER_CREDITS - TX_BURST, tx_pkts);
    make_tlp();
    hold_tx();
    expect_tx();
    phy_word(fc_dllp(CODE_UPD, PEER_CREDITS + 8'd2), 1'b1, 1'b1);
    drive_tx();
    make_tlp();
    expect_tx();
    drive_tx();
    wait_tx_drain();
    check_count("TLPs after UpdateFC", base + PEER_CREDITS - TX_BURST + 2, tx_pkts);
    make_tlp();
    hold_tx();
    drop_tx();
    end_test();

    start_test("TLP receive");
    tlp_stall_en = 1'b1;
    for (i = 0; i < 4; i++) begin
      recv_tlp(1'b1);
    end
    recv_tlp(1'b0);
    recv_tlp(1'b1);
    end_test();

    start_test("link down");
    phy_stall_en = 1'b0;
    tlp_stall_en = 1'b0;
    @(negedge clk_i);
    phy_link_up_i = 1'b0;
    @(negedge clk_i);
    check_count("fc_initialized_o after link drop", 0, fc_initialized_o);
    tx_seq = '0;
    rx_seq = '0;
    repeat (4) @(negedge clk_i);
    bring_up(8'd2);
    base = tx_pkts;
    for (i = 0; i < 2; i++) begin
      make_tlp();
      expect_tx();
      drive_tx();
    end
    wait_tx_drain();
    check_count("TLPs after new bring-up", base + 2, tx_pkts);
    make_tlp();
    hold_tx();
    drop_tx();
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests, checks,
             errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* rtl/pcie_dl_top.sv */
`timescale 1ns/100ps

module pcie_dl_top #(
  parameter pcie_dl_pkg::credit_t RX_HDR_CREDITS = 8'd8,
  parameter int                   FC_REPEAT      = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  phy_link_up_i,
  // TLPs from the transaction layer
  input  pcie_dl_pkg::dl_word_t s_tlp_tdata_i,
  input  logic                  s_tlp_tvalid_i,
  input  logic                  s_tlp_tlast_i,
  output logic                  s_tlp_tready_o,
  // TLPs to the transaction layer
  output pcie_dl_pkg::dl_word_t m_tlp_tdata_o,
  output logic                  m_tlp_tvalid_o,
  output logic                  m_tlp_tlast_o,
  input  logic                  m_tlp_tready_i,
  // From the PHY
  input  pcie_dl_pkg::dl_word_t s_phy_tdata_i,
  input  logic                  s_phy_tvalid_i,
  input  logic                  s_phy_tlast_i,
  input  logic                  s_phy_tuser_i,
  output logic                  s_phy_tready_o,
  // To the PHY
  output pcie_dl_pkg::dl_word_t m_phy_tdata_o,
  output logic                  m_phy_tvalid_o,
  output logic                  m_phy_tlast_o,
  output logic                  m_phy_tuser_o,
  input  logic                  m_phy_tready_i,
  output logic                  fc_initialized_o
);
  import pcie_dl_pkg::*;

  dl_state_e link_state;
  logic      soft_rst;
  logic      fc1_seen;
  logic      fc2_seen;
  logic      fc2_sent;
  credit_t   credit_limit;
  logic      credit_upd;
  seq_num_t  ack_seq;
  logic      ack_vld;

  dl_stream_if tlp_phy_s ();
  dl_stream_if fc_phy_s ();
  dl_stream_if ack_phy_s ();
  dl_stream_if s_tlp_s ();
  dl_stream_if m_tlp_s ();
  dl_stream_if s_phy_s ();

  assign s_tlp_s.tdata  = s_tlp_tdata_i;
  assign s_tlp_s.tvalid = s_tlp_tvalid_i;
  assign s_tlp_s.tlast  = s_tlp_tlast_i;
  assign s_tlp_s.tuser  = 1'b0;
  assign s_tlp_tready_o = s_tlp_s.tready;

  assign m_tlp_tdata_o  = m_tlp_s.tdata;
  assign m_tlp_tvalid_o = m_tlp_s.tvalid;
  assign m_tlp_tlast_o  = m_tlp_s.tlast;
  assign m_tlp_s.tready = m_tlp_tready_i;

  assign s_phy_s.tdata  = s_phy_tdata_i;
  assign s_phy_s.tvalid = s_phy_tvalid_i;
  assign s_phy_s.tlast  = s_phy_tlast_i;
  assign s_phy_s.tuser  = s_phy_tuser_i;
  assign s_phy_tready_o = s_phy_s.tready;

  dl_link_ctrl link_ctrl_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .phy_link_up_i    (phy_link_up_i),
    .fc2_seen_i       (fc2_seen),
    .fc2_sent_i       (fc2_sent),
    .link_state_o     (link_state),
    .soft_rst_o       (soft_rst),
    .fc_initialized_o (fc_initialized_o)
  );

  dl_fc_init #(
    .RX_HDR_CREDITS (RX_HDR_CREDITS),
    .FC_REPEAT      (FC_REPEAT)
  ) fc_init_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .soft_rst_i   (soft_rst),
    .link_state_i (link_state),
    .fc1_seen_i   (fc1_seen),
    .fc2_seen_i   (fc2_seen),
    .fc2_sent_o   (fc2_sent),
    .fc_o         (fc_phy_s.src)
  );

  dl_tx_seq tx_seq_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .soft_rst_i     (soft_rst),
    .link_state_i   (link_state),
    .credit_limit_i (credit_limit),
    .credit_upd_i   (credit_upd),
    .ack_vld_i      (ack_vld),
    .ack_seq_i      (ack_seq),
    .tlp_i          (s_tlp_s.snk),
    .phy_o          (tlp_phy_s.src)
  );

  dl_rx_parse rx_parse_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .soft_rst_i     (soft_rst),
    .link_state_i   (link_state),
    .phy_i          (s_phy_s.snk),
    .tlp_o          (m_tlp_s.src),
    .ack_o          (ack_phy_s.src),
    .fc1_seen_o     (fc1_seen),
    .fc2_seen_o     (fc2_seen),
    .credit_limit_o (credit_limit),
    .credit_upd_o   (credit_upd),
    .ack_vld_o      (ack_vld),
    .ack_seq_o      (ack_seq)
  );

  // Link drop also abandons any packet the arbiter was in
  dl_phy_arb phy_arb_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i && !soft_rst),
    .ack_i      (ack_phy_s.snk),
    .fc_i       (fc_phy_s.snk),
    .tlp_i      (tlp_phy_s.snk),
    .m_tdata_o  (m_phy_tdata_o),
    .m_tvalid_o (m_phy_tvalid_o),
    .m_tlast_o  (m_phy_tlast_o),
    .m_tuser_o  (m_phy_tuser_o),
    .m_tready_i (m_phy_tready_i)
  );

endmodule

/* rtl/dl_phy_arb.sv */
`timescale 1ns/100ps

module dl_phy_arb (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  dl_stream_if.snk              ack_i,
  dl_stream_if.snk              fc_i,
  dl_stream_if.snk              tlp_i,
  output pcie_dl_pkg::dl_word_t m_tdata_o,
  output logic                  m_tvalid_o,
  output logic                  m_tlast_o,
  output logic                  m_tuser_o,
  input  logic                  m_tready_i
);

  typedef enum logic [1:0] {
    SEL_ACK,
    SEL_FC,
    SEL_TLP
  } sel_e;

  sel_e sel;
  sel_e sel_q;
  logic pkt_q;
  logic stall_q;

  // Grant stays put mid-packet and while a word is stalled
  always_comb begin
    if (pkt_q || stall_q) begin
      sel = sel_q;
    end else if (ack_i.tvalid) begin
      sel = SEL_ACK;
    end else if (fc_i.tvalid) begin
      sel = SEL_FC;
    end else begin
      sel = SEL_TLP;
    end
    case (sel)
      SEL_ACK: begin
        m_tdata_o  = ack_i.tdata;
        m_tvalid_o = ack_i.tvalid;
        m_tlast_o  = ack_i.tlast;
        m_tuser_o  = ack_i.tuser;
      end
      SEL_FC: begin
        m_tdata_o  = fc_i.tdata;
        m_tvalid_o = fc_i.tvalid;
        m_tlast_o  = fc_i.tlast;
        m_tuser_o  = fc_i.tuser;
      end
      default: begin
        m_tdata_o  = tlp_i.tdata;
        m_tvalid_o = tlp_i.tvalid;
        m_tlast_o  = tlp_i.tlast;
        m_tuser_o  = tlp_i.tuser;
      end
    endcase
  end

  assign ack_i.tready = m_tready_i && (sel == SEL_ACK);
  assign fc_i.tready  = m_tready_i && (sel == SEL_FC);
  assign tlp_i.tready = m_tready_i && (sel == SEL_TLP);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q   <= SEL_ACK;
      pkt_q   <= 1'b0;
      stall_q <= 1'b0;
    end else begin
      sel_q   <= sel;
      stall_q <= m_tvalid_o && !m_tready_i;
      if (m_tvalid_o && m_tready_i) begin
        pkt_q <= !m_tlast_o;
      end
    end
  end

endmodule

/* rtl/dl_rx_parse.sv */
`timescale 1ns/100ps

module dl_rx_parse (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   soft_rst_i,
  input  pcie_dl_pkg::dl_state_e link_state_i,
  dl_stream_if.snk               phy_i,
  dl_stream_if.src               tlp_o,
  dl_stream_if.src               ack_o,
  output logic                   fc1_seen_o,
  output logic                   fc2_seen_o,
  output pcie_dl_pkg::credit_t   credit_limit_o,
  output logic                   credit_upd_o,
  output logic                   ack_vld_o,
  output pcie_dl_pkg::seq_num_t  ack_seq_o
);
  import pcie_dl_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_FWD,
    RX_DROP
  } rx_state_e;

  rx_state_e  state_q;
  seq_num_t   exp_seq_q;
  logic       nak_q;
  logic       ack_pend_q;
  dl_word_t   ack_word_q;
  dllp_type_e dllp_type;
  logic       phy_xfer;
  logic       seq_ok;

  assign phy_xfer  = phy_i.tvalid && phy_i.tready;
  assign dllp_type = dllp_type_e'(phy_i.tdata[31:24]);
  assign seq_ok    = (phy_i.tdata[11:0] == exp_seq_q);

  // A new TLP header waits for the pending Ack or Nak
  always_comb begin
    case (state_q)
      RX_IDLE: phy_i.tready = phy_i.tuser || !ack_pend_q;
      RX_FWD:  phy_i.tready = tlp_o.tready;
      default: phy_i.tready = 1'b1;
    endcase
  end

  assign tlp_o.tvalid = (state_q == RX_FWD) && phy_i.tvalid;
  assign tlp_o.tdata  = phy_i.tdata;
  assign tlp_o.tlast  = phy_i.tlast;
  assign tlp_o.tuser  = 1'b0;

  assign ack_o.tvalid = ack_pend_q;
  assign ack_o.tdata  = ack_word_q;
  assign ack_o.tlast  = 1'b1;
  assign ack_o.tuser  = 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= RX_IDLE;
      exp_seq_q      <= '0;
      nak_q          <= 1'b0;
      ack_pend_q     <= 1'b0;
      fc1_seen_o     <= 1'b0;
      fc2_seen_o     <= 1'b0;
      credit_limit_o <= '0;
      credit_upd_o   <= 1'b0;
      ack_vld_o      <= 1'b0;
      ack_seq_o      <= '0;
    end else if (soft_rst_i) begin
      state_q        <= RX_IDLE;
      exp_seq_q      <= '0;
      nak_q          <= 1'b0;
      ack_pend_q     <= 1'b0;
      fc1_seen_o     <= 1'b0;
      fc2_seen_o     <= 1'b0;
      credit_limit_o <= '0;
      credit_upd_o   <= 1'b0;
      ack_vld_o      <= 1'b0;
      ack_seq_o      <= '0;
    end else begin
      credit_upd_o <= 1'b0;
      ack_vld_o    <= 1'b0;
      if (ack_o.tvalid && ack_o.tready) begin
        ack_pend_q <= 1'b0;
      end
      case (state_q)
        RX_IDLE: begin
          if (phy_xfer && phy_i.tuser) begin
            case (dllp_type)
              DLLP_ACK: begin
                ack_vld_o <= 1'b1;
                ack_seq_o <= phy_i.tdata[11:0];
              end
              // No replay, so a Nak changes nothing
              DLLP_NAK: ;
              DLLP_INITFC1, DLLP_UPDATEFC: begin
                credit_limit_o <= phy_i.tdata[19:12];
                credit_upd_o   <= 1'b1;
                if (dllp_type == DLLP_INITFC1) begin
                  fc1_seen_o <= 1'b1;
                end
              end
              DLLP_INITFC2: begin
                fc1_seen_o <= 1'b1;
                fc2_seen_o <= 1'b1;
              end
              default: ;
            endcase
          end else if (phy_xfer) begin
            fc2_seen_o <= 1'b1;
            if (!phy_i.tlast) begin
              state_q <= (link_state_i == DL_ACTIVE && seq_ok) ? RX_FWD : RX_DROP;
              nak_q   <= (link_state_i == DL_ACTIVE) && !seq_ok;
            end
          end
        end
        RX_FWD: begin
          if (phy_xfer && phy_i.tlast) begin
            state_q    <= RX_IDLE;
            exp_seq_q  <= exp_seq_q + 1'b1;
            ack_pend_q <= 1'b1;
          end
        end
        RX_DROP: begin
          if (phy_xfer && phy_i.tlast) begin
            state_q    <= RX_IDLE;
            ack_pend_q <= nak_q;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Response word built at the end of each TLP
  always_ff @(posedge clk_i) begin
    if (phy_xfer && phy_i.tlast && state_q != RX_IDLE) begin
      if (state_q == RX_FWD) begin
        ack_word_q <= dllp_word(DLLP_ACK, '0, exp_seq_q);
      end else begin
        ack_word_q <= dllp_word(DLLP_NAK, '0, exp_seq_q - 1'b1);
      end
    end
  end

endmodule

/* rtl/dl_tx_seq.sv */
`timescale 1ns/100ps

module dl_tx_seq (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   soft_rst_i,
  input  pcie_dl_pkg::dl_state_e link_state_i,
  input  pcie_dl_pkg::credit_t   credit_limit_i,
  input  logic                   credit_upd_i,
  input  logic                   ack_vld_i,
  input  pcie_dl_pkg::seq_num_t  ack_seq_i,
  dl_stream_if.snk               tlp_i,
  dl_stream_if.src               phy_o
);
  import pcie_dl_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_DATA
  } tx_state_e;

  tx_state_e state_q;
  seq_num_t  next_seq_q;
  seq_num_t  last_ack_q;
  credit_t   credits_used_q;
  credit_t   credit_limit_q;
  credit_t   credit_room;
  logic      can_start;

  // Modulo 256 compare of used against limit
  assign credit_room = credit_limit_q - credits_used_q;
  assign can_start   = (link_state_i == DL_ACTIVE) && (credit_room != '0) && !credit_room[7];

  always_comb begin
    phy_o.tuser = 1'b0;
    if (state_q == TX_DATA) begin
      phy_o.tvalid = tlp_i.tvalid;
      phy_o.tdata  = tlp_i.tdata;
      phy_o.tlast  = tlp_i.tlast;
      tlp_i.tready = phy_o.tready;
    end else begin
      phy_o.tvalid = (state_q == TX_HDR);
      phy_o.tdata  = tlp_hdr(next_seq_q);
      phy_o.tlast  = 1'b0;
      tlp_i.tready = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= TX_IDLE;
      next_seq_q     <= '0;
      last_ack_q     <= '0;
      credits_used_q <= '0;
      credit_limit_q <= '0;
    end else if (soft_rst_i) begin
      state_q        <= TX_IDLE;
      next_seq_q     <= '0;
      last_ack_q     <= '0;
      credits_used_q <= '0;
      credit_limit_q <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (tlp_i.tvalid && can_start) begin
            state_q <= TX_HDR;
          end
        end
        TX_HDR: begin
          if (phy_o.tready) begin
            state_q <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (tlp_i.tvalid && phy_o.tready && tlp_i.tlast) begin
            state_q        <= TX_IDLE;
            next_seq_q     <= next_seq_q + 1'b1;
            credits_used_q <= credits_used_q + 1'b1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
      if (credit_upd_i) begin
        credit_limit_q <= credit_limit_i;
      end
      // Kept for the replay buffer
      if (ack_vld_i) begin
        last_ack_q <= ack_seq_i;
      end
    end
  end

endmodule

/* rtl/dl_fc_init.sv */
`timescale 1ns/100ps

module dl_fc_init #(
  parameter pcie_dl_pkg::credit_t RX_HDR_CREDITS = 8'd8,
  parameter int                   FC_REPEAT      = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   soft_rst_i,
  input  pcie_dl_pkg::dl_state_e link_state_i,
  input  logic                   fc1_seen_i,
  input  logic                   fc2_seen_i,
  output logic                   fc2_sent_o,
  dl_stream_if.src               fc_o
);
  import pcie_dl_pkg::*;

  localparam int GAP_W = $clog2(FC_REPEAT + 1);

  logic [GAP_W-1:0] gap_q;
  logic             offer_q;
  dllp_type_e       type_q;
  logic             fc_done;

  // Nothing left to send once both sides agree
  assign fc_done = fc2_seen_i && fc2_sent_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gap_q      <= '0;
      offer_q    <= 1'b0;
      type_q     <= DLLP_INITFC1;
      fc2_sent_o <= 1'b0;
    end else if (soft_rst_i) begin
      gap_q      <= '0;
      offer_q    <= 1'b0;
      type_q     <= DLLP_INITFC1;
      fc2_sent_o <= 1'b0;
    end else if (link_state_i != DL_INIT) begin
      gap_q   <= '0;
      offer_q <= 1'b0;
    end else if (offer_q) begin
      if (fc_o.tready) begin
        offer_q <= 1'b0;
        gap_q   <= '0;
        if (type_q == DLLP_INITFC2) begin
          fc2_sent_o <= 1'b1;
        end
      end
    end else if (gap_q == GAP_W'(FC_REPEAT - 1)) begin
      gap_q <= '0;
      if (!fc_done) begin
        offer_q <= 1'b1;
        type_q  <= (fc1_seen_i || fc2_seen_i) ? DLLP_INITFC2 : DLLP_INITFC1;
      end
    end else begin
      gap_q <= gap_q + 1'b1;
    end
  end

  assign fc_o.tvalid = offer_q;
  assign fc_o.tdata  = dllp_word(type_q, RX_HDR_CREDITS, '0);
  assign fc_o.tlast  = 1'b1;
  assign fc_o.tuser  = 1'b1;

endmodule

/* rtl/dl_link_ctrl.sv */
`timescale 1ns/100ps

module dl_link_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   phy_link_up_i,
  input  logic                   fc2_seen_i,
  input  logic                   fc2_sent_i,
  output pcie_dl_pkg::dl_state_e link_state_o,
  output logic                   soft_rst_o,
  output logic                   fc_initialized_o
);
  import pcie_dl_pkg::*;

  dl_state_e state_d;
  logic      link_drop;

  always_comb begin
    state_d   = link_state_o;
    link_drop = 1'b0;
    case (link_state_o)
      DL_INACTIVE: begin
        if (phy_link_up_i) begin
          state_d = DL_INIT;
        end
      end
      DL_INIT: begin
        if (!phy_link_up_i) begin
          state_d   = DL_INACTIVE;
          link_drop = 1'b1;
        end else if (fc2_seen_i && fc2_sent_i) begin
          state_d = DL_ACTIVE;
        end
      end
      DL_ACTIVE: begin
        if (!phy_link_up_i) begin
          state_d   = DL_INACTIVE;
          link_drop = 1'b1;
        end
      end
      default: state_d = DL_INACTIVE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      link_state_o <= DL_INACTIVE;
      soft_rst_o   <= 1'b0;
    end else begin
      link_state_o <= state_d;
      soft_rst_o   <= link_drop;
    end
  end

  assign fc_initialized_o = (link_state_o == DL_ACTIVE);

endmodule

/* rtl/dl_stream_if.sv */
`timescale 1ns/100ps

interface dl_stream_if;
  import pcie_dl_pkg::*;

  dl_word_t tdata;
  logic     tvalid;
  logic     tlast;
  // Set on DLLP words
  logic     tuser;
  logic     tready;

  modport src (output tdata, output tvalid, output tlast, output tuser, input tready);
  modport snk (input tdata, input tvalid, input tlast, input tuser, output tready);

endinterface

/* rtl/pcie_dl_pkg.sv */
package pcie_dl_pkg;

  typedef logic [31:0] dl_word_t;
  typedef logic [11:0] seq_num_t;
  typedef logic [7:0]  credit_t;

  // DLLP type code in the top byte of the word
  typedef enum logic [7:0] {
    DLLP_ACK      = 8'h00,
    DLLP_NAK      = 8'h10,
    DLLP_INITFC1  = 8'h40,
    DLLP_UPDATEFC = 8'h80,
    DLLP_INITFC2  = 8'hC0
  } dllp_type_e;

  typedef enum logic [1:0] {
    DL_INACTIVE,
    DL_INIT,
    DL_ACTIVE
  } dl_state_e;

  // Credits in 19:12, sequence number in 11:0
  function automatic dl_word_t dllp_word(dllp_type_e dtype, credit_t credits,
                                         seq_num_t seq);
    return {dtype, 4'h0, credits, seq};
  endfunction

  // First word of a TLP on the PHY stream
  function automatic dl_word_t tlp_hdr(seq_num_t seq);
    return {20'h0, seq};
  endfunction

endpackage
